// File: Makefile
# build and run the LCD subsystem testbench with Verilator
VERILATOR = verilator
FLAGS = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP = lcdTb
RTL_TOP = lcdSubsystem
FILELIST = src.f
BUILD_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status of the simulation is the test result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: logic/lcdArbiter.sv
////////////////////////////////////////
// shares the SPI master between init and fill
// init wins on an idle bus, a grant lasts the whole burst
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdArbiter import lcdPkg::*; (
	input wire clk,
	input wire reset,
	lcdBus.transmitter initBus,
	lcdBus.transmitter fillBus,
	output logic load,
	output logic load16,
	output lcdWord_t word,
	input wire busy
);

	logic owner;   // 0 init, 1 fill
	logic locked;  // burst in progress
	logic ownerReq;
	logic initGrant;
	logic fillGrant;

	assign ownerReq = owner ? fillBus.req : initBus.req;

	always_ff @(posedge clk) begin
		if (reset) begin
			owner <= 1'b0;
			locked <= 1'b0;
		end else if (!locked) begin
			if (initBus.req) begin
				owner <= 1'b0; // fixed priority
				locked <= 1'b1;
			end else if (fillBus.req) begin
				owner <= 1'b1;
				locked <= 1'b1;
			end
		end else if (!ownerReq) begin
			locked <= 1'b0; // burst over, rearbitrate next cycle
		end
	end

	assign initGrant = locked & ~owner;
	assign fillGrant = locked & owner;
	assign initBus.grant = initGrant;
	assign fillBus.grant = fillGrant;
	assign initBus.busy = initGrant ? busy : 1'b1; // loser stalls
	assign fillBus.busy = fillGrant ? busy : 1'b1;

	// only the owner reaches the transmitter
	always_comb begin
		load = 1'b0;
		load16 = 1'b0;
		word = '0;
		if (initGrant) begin
			load = initBus.load;
			load16 = initBus.load16;
			word = initBus.word;
		end else if (fillGrant) begin
			load = fillBus.load;
			load16 = fillBus.load16;
			word = fillBus.word;
		end
	end

endmodule

`default_nettype wire

// File: logic/lcdBus.sv
////////////////////////////////////////
// link between one requester and the arbiter
// requester holds req for a whole burst, strobes on grant
// ungranted side always sees busy high
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface lcdBus import lcdPkg::*; ();

	logic req;      // level, held for the burst
	logic grant;    // held while req stays high
	logic load;     // byte or release strobe
	logic load16;   // pixel word strobe
	lcdWord_t word;
	logic busy;

	modport requester (output req, load, load16, word, input grant, busy);

	// arbiter side
	modport transmitter (input req, load, load16, word, output grant, busy);

endinterface

`default_nettype wire

// File: logic/lcdInitSequencer.sv
////////////////////////////////////////
// plays the package power-up list once after reset
// initDone goes high after the closing release is loaded
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdInitSequencer import lcdPkg::*; (
	input wire clk,
	input wire reset,
	lcdBus.requester bus,
	output logic initDone
);

	localparam int IDX_W = $clog2(INIT_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(INIT_LEN - 1);

	logic [IDX_W-1:0] idx; // next table entry
	logic loadPending;     // busy not yet up after a load
	logic issue;
	logic reqReg;

	assign issue = bus.grant & ~bus.busy & ~loadPending & ~initDone;

	always_ff @(posedge clk) begin
		if (reset) begin
			idx <= '0;
			loadPending <= 1'b0;
			initDone <= 1'b0;
			reqReg <= 1'b0;
		end else begin
			loadPending <= issue;
			if (!initDone)
				reqReg <= 1'b1; // ask right away after reset
			if (issue) begin
				if (idx == LAST_IDX) begin
					reqReg <= 1'b0; // release entry just went out
					initDone <= 1'b1;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	assign bus.req = reqReg;
	assign bus.load = issue;  // every entry is a byte or a release
	assign bus.load16 = 1'b0;
	assign bus.word = INIT_TABLE[idx];

endmodule

`default_nettype wire

// File: logic/lcdPixelFill.sv
////////////////////////////////////////
// streams one colour into panel memory
// RAMWR, then fillCount pixels, then a release
// fillStart is ignored while fillBusy is high
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdPixelFill import lcdPkg::*; (
	input wire clk,
	input wire reset,
	input wire fillStart,
	input wire [15:0] fillColor,
	input wire [COUNT_W-1:0] fillCount,
	lcdBus.requester bus,
	output logic fillBusy
);

	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] CMD = 2'd1;
	localparam logic [1:0] PIXELS = 2'd2;
	localparam logic [1:0] RELEASE = 2'd3;

	logic [1:0] state;
	logic [15:0] color;              // captured at start
	logic [COUNT_W-1:0] remaining;   // pixels still to send
	logic loadPending;
	logic canLoad;
	lcdWord_t txWord;

	assign canLoad = bus.grant & ~bus.busy & ~loadPending;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			loadPending <= 1'b0;
		end else begin
			loadPending <= bus.load | bus.load16;
			case (state)
				IDLE: if (fillStart) state <= CMD;
				CMD: if (canLoad) state <= (remaining == '0) ? RELEASE : PIXELS;
				PIXELS: if (canLoad && remaining == COUNT_W'(1)) state <= RELEASE;
				RELEASE: if (canLoad) state <= IDLE; // req drops with it
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && fillStart) begin
			color <= fillColor;
			remaining <= fillCount;
		end else if (state == PIXELS && canLoad) begin
			remaining <= remaining - 1'b1;
		end
	end

	always_comb begin
		txWord = '0;
		case (state)
			CMD: txWord.ctrl.payload = CMD_RAMWR; // command, dcx 0
			PIXELS: txWord.pixel = color;
			RELEASE: txWord.ctrl.csRelease = 1'b1;
			default: txWord = '0;
		endcase
	end

	assign fillBusy = (state != IDLE);
	assign bus.req = fillBusy;
	assign bus.load = canLoad & (state == CMD || state == RELEASE);
	assign bus.load16 = canLoad & (state == PIXELS);
	assign bus.word = txWord;

endmodule

`default_nettype wire

// File: logic/lcdPkg.sv
////////////////////////////////////////
// shared types and constants for the LCD output path
// transmit word views, panel opcodes and the power-up list
// import into any block that builds or decodes SPI words
////////////////////////////////////////
`default_nettype none

package lcdPkg;

	// one transmit word, read as a control byte or as a pixel
	typedef union packed {
		struct packed {
			logic [5:0] unused;
			logic dcx;       // 0 command, 1 data
			logic csRelease; // raise CSX, shift nothing
			logic [7:0] payload;
		} ctrl;
		logic [15:0] pixel; // RGB565
	} lcdWord_t;

	localparam logic [7:0] CMD_RAMWR = 8'h2C; // memory write
	localparam int COUNT_W = 16;              // pixel count width
	localparam int INIT_LEN = 6;

	// power-up list, MADCTL stays at its reset default
	localparam lcdWord_t INIT_TABLE [INIT_LEN] = '{
		16'h0001, // software reset
		16'h0011, // sleep out
		16'h003A, // pixel format set
		16'h0255, // 16 bpp on both interfaces, data
		16'h0029, // display on
		16'h0100  // release CSX
	};

endpackage

`default_nettype wire

// File: logic/lcdSpi.sv
////////////////////////////////////////
// write-only 4-wire SPI master for the panel
// load sends a byte or releases CSX, load16 sends a pixel
// strobe only while busy is low
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdSpi import lcdPkg::*; #(
	parameter int SCK_DIV_LOG2 = 1 // SCK period is 2**SCK_DIV_LOG2 clocks, min 1
) (
	input wire clk,
	input wire reset,
	input wire load,        // byte or release
	input wire load16,      // pixel word
	input wire lcdWord_t word,
	output logic busy,
	output logic DCX,       // 0 command, 1 data
	output logic CSX,       // chip select, active low
	output logic SDO,
	output logic SCK
);

	localparam int CNT_W = SCK_DIV_LOG2 + 4; // enough for 16 SCK periods
	localparam logic [CNT_W-1:0] BYTE_LAST = CNT_W'((8 << SCK_DIV_LOG2) - 1);
	localparam logic [CNT_W-1:0] WORD_LAST = '1;

	logic [15:0] shiftReg;      // MSB goes out first
	logic [CNT_W-1:0] cycleCnt; // clocks into the current transfer
	logic isWord;               // 16-bit transfer in flight
	logic csxReg;
	logic dcxReg;
	logic startByte;
	logic lastCycle;
	logic sckFall;

	// a release command starts nothing on the wire
	assign startByte = load & ~word.ctrl.csRelease & ~busy;
	assign lastCycle = busy & (cycleCnt == (isWord ? WORD_LAST : BYTE_LAST));
	// last clock of the high half, next bit goes out here
	assign sckFall = busy & (&cycleCnt[SCK_DIV_LOG2-1:0]);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			isWord <= 1'b0;
			cycleCnt <= '0;
		end else if (!busy && (startByte || load16)) begin
			busy <= 1'b1;
			isWord <= load16;
			cycleCnt <= '0;
		end else if (busy) begin
			cycleCnt <= cycleCnt + 1'b1;
			if (lastCycle)
				busy <= 1'b0; // done after 8 or 16 SCK periods
		end
	end

	// payload register, MSB aligned for both views
	always_ff @(posedge clk) begin
		if (!busy && load16)
			shiftReg <= word.pixel;
		else if (startByte)
			shiftReg <= {word.ctrl.payload, 8'h00};
		else if (sckFall)
			shiftReg <= {shiftReg[14:0], 1'b0};
	end

	// CSX and DCX hold their level between transfers
	always_ff @(posedge clk) begin
		if (reset) begin
			csxReg <= 1'b1; // deselected until the first command
			dcxReg <= 1'b0;
		end else if (!busy && load16) begin
			csxReg <= 1'b0;
			dcxReg <= 1'b1; // pixels are always data
		end else if (!busy && load) begin
			csxReg <= word.ctrl.csRelease;
			dcxReg <= word.ctrl.dcx;
		end
	end

	// select drops on the load cycle itself for setup margin
	assign CSX = (startByte || (load16 && !busy)) ? 1'b0 : csxReg;
	assign DCX = dcxReg;
	assign SDO = busy & shiftReg[15];
	assign SCK = busy & cycleCnt[SCK_DIV_LOG2-1]; // low half first

endmodule

`default_nettype wire

// File: logic/lcdSubsystem.sv
////////////////////////////////////////
// LCD output top, init and fill share one SPI master
// pulse fillStart once initDone is high or queue it early
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdSubsystem import lcdPkg::*; #(
	parameter int SCK_DIV_LOG2 = 1 // raise for slower panels
) (
	input wire clk,
	input wire reset,
	input wire fillStart,
	input wire [15:0] fillColor,      // RGB565
	input wire [COUNT_W-1:0] fillCount,
	output logic initDone,
	output logic fillBusy,
	output logic DCX,
	output logic CSX,
	output logic SDO,
	output logic SCK
);

	lcdBus initBus ();
	lcdBus fillBus ();

	// granted requester to transmitter
	logic load;
	logic load16;
	lcdWord_t word;
	logic busy;

	lcdInitSequencer lcdInitSequencer_inst (
		.clk(clk),
		.reset(reset),
		.bus(initBus.requester),
		.initDone(initDone)
	);

	lcdPixelFill lcdPixelFill_inst (
		.clk(clk),
		.reset(reset),
		.fillStart(fillStart),
		.fillColor(fillColor),
		.fillCount(fillCount),
		.bus(fillBus.requester),
		.fillBusy(fillBusy)
	);

	lcdArbiter lcdArbiter_inst (
		.clk(clk),
		.reset(reset),
		.initBus(initBus.transmitter),
		.fillBus(fillBus.transmitter),
		.load(load),
		.load16(load16),
		.word(word),
		.busy(busy)
	);

	lcdSpi #(
		.SCK_DIV_LOG2(SCK_DIV_LOG2)
	) lcdSpi_inst (
		.clk(clk),
		.reset(reset),
		.load(load),
		.load16(load16),
		.word(word),
		.busy(busy),
		.DCX(DCX),
		.CSX(CSX),
		.SDO(SDO),
		.SCK(SCK)
	);

endmodule

`default_nettype wire

// File: src.f
logic/lcdPkg.sv
logic/lcdBus.sv
logic/lcdSpi.sv
logic/lcdArbiter.sv
logic/lcdInitSequencer.sv
logic/lcdPixelFill.sv
logic/lcdSubsystem.sv
verif/tbClock.sv
verif/lcdTb.sv

// File: verif/lcdTb.sv
////////////////////////////////////////
// table-driven testbench for the LCD subsystem
// decodes the SPI lines and checks init and fill streams
// run through the Makefile, exit status gives the result
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lcdTb import lcdPkg::*; ();

	localparam int SCK_DIV_LOG2 = 1;
	localparam int SCK_PERIOD = 1 << SCK_DIV_LOG2; // clocks per SCK period
	localparam int NUM_ROWS = 5;

	typedef struct {
		string name;
		logic [15:0] color;
		logic [COUNT_W-1:0] count;
		logic early; // start pulsed while init still runs
	} fillRow_t;

	logic clk;
	logic reset;
	logic fillStart;
	logic [15:0] fillColor;
	logic [COUNT_W-1:0] fillCount;
	logic initDone;
	logic fillBusy;
	logic DCX;
	logic CSX;
	logic SDO;
	logic SCK;

	fillRow_t rows [NUM_ROWS];
	integer seed;
	int sumCounts;
	int timeoutLimit = 0;
	int cycleCount = 0;

	// SPI line decoder state
	logic prevSck = 1'b0;
	logic prevCsx = 1'b1;
	logic lastDcx = 1'b0;
	logic [15:0] shiftIn = '0;
	int bitCount = 0;
	int sinceRise = 0; // clocks since the last SCK rise
	lcdWord_t evWord [$];
	logic evPixel [$];
	logic evDcx [$];

	tbClock #(.PERIOD(40), .RESET_CYCLES(16)) tbClock_inst (.clk(clk), .reset(reset));

	lcdSubsystem #(
		.SCK_DIV_LOG2(SCK_DIV_LOG2)
	) lcdSubsystem_inst (
		.clk(clk),
		.reset(reset),
		.fillStart(fillStart),
		.fillColor(fillColor),
		.fillCount(fillCount),
		.initDone(initDone),
		.fillBusy(fillBusy),
		.DCX(DCX),
		.CSX(CSX),
		.SDO(SDO),
		.SCK(SCK)
	);

	task failRun(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task checkWord(input string name, input lcdWord_t expected, input lcdWord_t actual);
		if (actual !== expected)
			failRun($sformatf("CHECK FAILED %s expected %h actual %h", name,
				expected.pixel, actual.pixel));
	endtask

	task checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			failRun($sformatf("CHECK FAILED %s expected %b actual %b", name, expected, actual));
	endtask

	task setRow(input int idx, input string name, input logic [15:0] color,
		input logic [COUNT_W-1:0] count, input logic early);
		rows[idx].name = name;
		rows[idx].color = color;
		rows[idx].count = count;
		rows[idx].early = early;
	endtask

	// 8 bits is a control byte, 16 bits a pixel
	task closeTransfer();
		lcdWord_t w;
		w = '0;
		if (bitCount == 16) begin
			w.pixel = shiftIn;
		end else begin
			w.ctrl.dcx = lastDcx;
			w.ctrl.payload = shiftIn[7:0];
		end
		evWord.push_back(w);
		evPixel.push_back(bitCount == 16);
		evDcx.push_back(lastDcx);
		bitCount = 0;
	endtask

	// sampled mid-cycle so SCK and CSX edges show up as level changes
	always @(negedge clk) begin
		lcdWord_t rel;
		sinceRise = sinceRise + 1;
		if (bitCount == 8 && (sinceRise > SCK_PERIOD || (CSX && !prevCsx)))
			closeTransfer(); // gap after a byte
		if (SCK && !prevSck && !CSX) begin
			shiftIn = {shiftIn[14:0], SDO}; // MSB first
			bitCount = bitCount + 1;
			sinceRise = 0;
			lastDcx = DCX;
			if (bitCount == 16)
				closeTransfer();
		end
		if (CSX && !prevCsx) begin
			if (bitCount != 0)
				failRun("chip select rose in the middle of a transfer");
			rel = '0;
			rel.ctrl.csRelease = 1'b1;
			rel.ctrl.dcx = DCX;
			evWord.push_back(rel);
			evPixel.push_back(1'b0);
			evDcx.push_back(DCX);
		end
		prevSck = SCK;
		prevCsx = CSX;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > timeoutLimit)
			failRun($sformatf("run timed out after %0d clock cycles", timeoutLimit));
	end

	task expectEvent(input string name, input lcdWord_t expWord, input logic expPixel,
		input logic expDcx);
		if (evWord.size() == 0) begin
			failRun($sformatf("%s never appeared on the SPI lines", name));
		end else begin
			checkWord(name, expWord, evWord.pop_front());
			checkFlag({name, " 16-bit"}, expPixel, evPixel.pop_front());
			checkFlag({name, " DCX"}, expDcx, evDcx.pop_front());
		end
	endtask

	task checkInitStream();
		lcdWord_t e;
		for (int i = 0; i < INIT_LEN; i++) begin
			e = INIT_TABLE[i];
			if (e.ctrl.csRelease)
				e.ctrl.payload = 8'h00; // release shifts no bits
			expectEvent($sformatf("init entry %0d", i), e, 1'b0, e.ctrl.dcx);
		end
	endtask

	task checkFillStream(input int r);
		lcdWord_t w;
		w = '0;
		w.ctrl.payload = CMD_RAMWR;
		expectEvent({rows[r].name, " RAMWR"}, w, 1'b0, 1'b0);
		for (int i = 0; i < int'(rows[r].count); i++) begin
			w.pixel = rows[r].color;
			expectEvent($sformatf("%s pixel %0d", rows[r].name, i), w, 1'b1, 1'b1);
		end
		w = '0;
		w.ctrl.csRelease = 1'b1;
		expectEvent({rows[r].name, " release"}, w, 1'b0, 1'b0);
	endtask

	// start pulse, then a second one that must be ignored
	task startFill(input int r);
		@(posedge clk);
		#1;
		fillStart = 1'b1;
		fillColor = rows[r].color;
		fillCount = rows[r].count;
		@(posedge clk);
		#1;
		fillStart = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		checkFlag({rows[r].name, " busy before restart"}, 1'b1, fillBusy);
		fillStart = 1'b1;
		fillColor = ~rows[r].color;
		fillCount = rows[r].count + COUNT_W'(2);
		@(posedge clk);
		#1;
		fillStart = 1'b0;
	endtask

	task settle();
		repeat (2) @(posedge clk);
		#1;
	endtask

	initial begin
		fillStart = 1'b0;
		fillColor = '0;
		fillCount = '0;
		seed = 32'h650f60d4;
		setRow(0, "early fill", 16'hF800, COUNT_W'(3), 1'b1);
		setRow(1, "count zero", 16'h07E0, COUNT_W'(0), 1'b0);
		setRow(2, "count one", 16'h001F, COUNT_W'(1), 1'b0);
		setRow(3, "random colour", 16'($random(seed)), COUNT_W'(5), 1'b0);
		setRow(4, "long run", 16'hA5A5, COUNT_W'(12), 1'b0);
		sumCounts = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			sumCounts = sumCounts + int'(rows[r].count);
		timeoutLimit = 2 * (16 * (INIT_LEN + NUM_ROWS) + 32 * sumCounts) + 200;

		repeat (4) @(negedge clk); // still inside reset
		checkFlag("reset CSX", 1'b1, CSX);
		checkFlag("reset SCK", 1'b0, SCK);
		checkFlag("reset SDO", 1'b0, SDO);
		checkFlag("reset DCX", 1'b0, DCX);
		checkFlag("reset initDone", 1'b0, initDone);
		checkFlag("reset fillBusy", 1'b0, fillBusy);
		while (reset) @(negedge clk);

		if (rows[0].early)
			startFill(0); // has to wait behind the init burst
		do @(negedge clk); while (!initDone);
		checkFlag("CSX high when initDone rises", 1'b1, CSX); // release already loaded
		settle();
		checkInitStream();

		for (int r = 0; r < NUM_ROWS; r++) begin
			if (!rows[r].early)
				startFill(r);
			do @(negedge clk); while (fillBusy);
			checkFlag({rows[r].name, " CSX high when fillBusy falls"}, 1'b1, CSX);
			settle();
			checkFillStream(r);
		end

		repeat (50) @(posedge clk);
		#1;
		checkFlag("no extra transfers", 1'b1, evWord.size() == 0 && bitCount == 0);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tbClock.sv
////////////////////////////////////////
// clock and reset source for the testbench
// reset is held for the first RESET_CYCLES edges
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int PERIOD = 40,      // ns
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0; // released just after an edge, like any other input
	end

endmodule

`default_nettype wire
